// File: logic/ep_echo_config.svh
`ifndef EP_ECHO_CONFIG_SVH
`define EP_ECHO_CONFIG_SVH

// bytes held by each endpoint buffer, a power of two.
`define EP_BUF_DEPTH 64

// log2 of the buffer depth.
// pointers carry one extra wrap bit on top of this.
`define EP_PTR_W 6

`endif

// File: logic/ep_echo_pkg.sv
`default_nettype none

`include "ep_echo_config.svh"

package ep_echo_pkg;

    // one usb payload byte.
    typedef logic [7:0] ep_byte_t;

    // buffer pointer, the top bit is the wrap bit.
    typedef logic [`EP_PTR_W:0] ep_ptr_t;

    // fill or free count, 0 up to the full buffer depth.
    typedef logic [`EP_PTR_W:0] ep_level_t;

    // echo engine states.
    typedef enum logic [1:0] {
        ECHO_IDLE,
        ECHO_MOVE,
        ECHO_DRAIN
    } echo_state_t;

endpackage

`default_nettype wire

// File: logic/ep_out_buffer.sv
`default_nettype none

`include "ep_echo_config.svh"

// receive buffer for host OUT transactions.
// bytes of a transaction stay pending until the controller reports success.
module ep_out_buffer (
    input  wire logic                  clk12_i,
    input  wire logic                  rst_i,

    // controller side, device centric names.
    input  wire logic                  data_valid_i,
    input  wire ep_echo_pkg::ep_byte_t data_i,
    input  wire logic                  fill_trans_done_i,
    input  wire logic                  fill_trans_success_i,
    output logic                       full_o,

    // consumer side, only committed bytes are visible here.
    input  wire logic                  rd_en_i,
    output ep_echo_pkg::ep_byte_t      rd_data_o,
    output ep_echo_pkg::ep_level_t     level_o
);

    import ep_echo_pkg::*;

    ep_byte_t  mem [`EP_BUF_DEPTH];

    // speculative write, committed write and read pointers.
    ep_ptr_t   wr_spec_q;
    ep_ptr_t   wr_commit_q;
    ep_ptr_t   rd_q;

    // write pointer after the byte arriving this cycle, if any.
    ep_ptr_t   wr_spec_inc;
    ep_level_t spec_fill;

    assign wr_spec_inc = wr_spec_q + ep_ptr_t'(data_valid_i);

    // pending plus committed bytes, used for back-pressure.
    assign spec_fill = wr_spec_q - rd_q;
    assign full_o    = (spec_fill == ep_level_t'(`EP_BUF_DEPTH));

    // committed bytes not read yet.
    assign level_o   = wr_commit_q - rd_q;

    always_ff @(posedge clk12_i) begin
        if (rst_i) begin
            wr_spec_q   <= '0;
            wr_commit_q <= '0;
            rd_q        <= '0;
        end else begin
            if (fill_trans_done_i) begin
                if (fill_trans_success_i) begin
                    // make the whole packet visible to the reader.
                    wr_commit_q <= wr_spec_inc;
                    wr_spec_q   <= wr_spec_inc;
                end else begin
                    // drop everything written since the last commit.
                    wr_spec_q   <= wr_commit_q;
                end
            end else begin
                wr_spec_q <= wr_spec_inc;
            end

            if (rd_en_i) begin
                rd_q <= rd_q + ep_ptr_t'(1);
            end
        end
    end

    // byte storage and registered read port.
    always_ff @(posedge clk12_i) begin
        if (data_valid_i) begin
            mem[wr_spec_q[`EP_PTR_W-1:0]] <= data_i;
        end
        if (rd_en_i) begin
            rd_data_o <= mem[rd_q[`EP_PTR_W-1:0]];
        end
    end

    // the controller has to respect full, nothing else stops it.
    a_no_write_when_full: assert property (
        @(posedge clk12_i) disable iff (rst_i)
        data_valid_i |-> !full_o
    ) else $error("ep_out_buffer: byte written while full");

    // the consumer may only read bytes that were committed.
    a_no_read_when_empty: assert property (
        @(posedge clk12_i) disable iff (rst_i)
        rd_en_i |-> (level_o != '0)
    ) else $error("ep_out_buffer: read from empty committed region");

endmodule

`default_nettype wire

// File: logic/ep_in_buffer.sv
`default_nettype none

`include "ep_echo_config.svh"

// transmit buffer for host IN transactions.
// popped bytes are only released once the transaction succeeds,
// a failed transaction rewinds so the retry sends the same bytes.
module ep_in_buffer (
    input  wire logic                  clk12_i,
    input  wire logic                  rst_i,

    // producer side, a write is committed at once.
    input  wire logic                  wr_en_i,
    input  wire ep_echo_pkg::ep_byte_t wr_data_i,
    output ep_echo_pkg::ep_level_t     free_o,

    // controller side, device centric names.
    input  wire logic                  pop_data_i,
    input  wire logic                  pop_trans_done_i,
    input  wire logic                  pop_trans_success_i,
    output logic                       data_available_o,
    output ep_echo_pkg::ep_byte_t      data_o
);

    import ep_echo_pkg::*;

    ep_byte_t  mem [`EP_BUF_DEPTH];

    // write, speculative read and committed read pointers.
    ep_ptr_t   wr_q;
    ep_ptr_t   rd_spec_q;
    ep_ptr_t   rd_commit_q;

    // read pointer after the pop of this cycle, if any.
    ep_ptr_t   rd_spec_inc;
    ep_level_t used;

    assign rd_spec_inc = rd_spec_q + ep_ptr_t'(pop_data_i);

    // space is only returned once the host acknowledged the bytes.
    assign used   = wr_q - rd_commit_q;
    assign free_o = ep_level_t'(`EP_BUF_DEPTH) - used;

    assign data_available_o = (rd_spec_q != wr_q);

    // the controller sees the next byte without a read strobe.
    assign data_o = mem[rd_spec_q[`EP_PTR_W-1:0]];

    always_ff @(posedge clk12_i) begin
        if (rst_i) begin
            wr_q        <= '0;
            rd_spec_q   <= '0;
            rd_commit_q <= '0;
        end else begin
            if (wr_en_i) begin
                wr_q <= wr_q + ep_ptr_t'(1);
            end

            if (pop_trans_done_i) begin
                if (pop_trans_success_i) begin
                    // host acknowledged, release the sent bytes.
                    rd_commit_q <= rd_spec_inc;
                    rd_spec_q   <= rd_spec_inc;
                end else begin
                    // no ack, go back for the retry.
                    rd_spec_q   <= rd_commit_q;
                end
            end else begin
                rd_spec_q <= rd_spec_inc;
            end
        end
    end

    always_ff @(posedge clk12_i) begin
        if (wr_en_i) begin
            mem[wr_q[`EP_PTR_W-1:0]] <= wr_data_i;
        end
    end

    // the controller only pops while a byte is shown.
    a_no_pop_when_empty: assert property (
        @(posedge clk12_i) disable iff (rst_i)
        pop_data_i |-> data_available_o
    ) else $error("ep_in_buffer: pop without data available");

    // the producer must keep its writes within the free space.
    a_no_write_when_full: assert property (
        @(posedge clk12_i) disable iff (rst_i)
        wr_en_i |-> (free_o != '0)
    ) else $error("ep_in_buffer: byte written with no free space");

endmodule

`default_nettype wire

// File: logic/ep_echo_engine.sv
`default_nettype none

`include "ep_echo_config.svh"

// moves committed OUT bytes into the IN buffer.
// reads are registered and the returned byte is written one cycle later.
// at most two bytes are between the buffers at any time.
module ep_echo_engine (
    input  wire logic                   clk12_i,
    input  wire logic                   rst_i,

    // OUT buffer read port.
    input  wire ep_echo_pkg::ep_level_t out_level_i,
    output logic                        out_rd_en_o,
    input  wire ep_echo_pkg::ep_byte_t  out_rd_data_i,

    // IN buffer write port.
    input  wire ep_echo_pkg::ep_level_t in_free_i,
    output logic                        in_wr_en_o,
    output ep_echo_pkg::ep_byte_t       in_wr_data_o
);

    import ep_echo_pkg::*;

    echo_state_t state_q;
    echo_state_t state_d;
    logic        rd_en_q;
    logic        wr_en_q;
    logic [1:0]  inflight_q;
    ep_level_t   avail;
    logic        issue;

    // committed bytes left once the read of this cycle is done.
    assign avail = out_level_i - ep_level_t'(rd_en_q);

    // a new read needs room for itself and for every byte in flight.
    // the first read goes out on the edge that leaves idle.
    assign issue = (state_q != ECHO_DRAIN) && (avail != '0) &&
                   (in_free_i > ep_level_t'(inflight_q));

    always_comb begin
        state_d = state_q;
        case (state_q)
            ECHO_IDLE: begin
                if (out_level_i != '0) begin
                    state_d = ECHO_MOVE;
                end
            end
            ECHO_MOVE: begin
                // nothing left to read so the pipeline empties.
                if (avail == '0) begin
                    state_d = ECHO_DRAIN;
                end
            end
            ECHO_DRAIN: begin
                if (inflight_q == 2'd0) begin
                    state_d = ECHO_IDLE;
                end
            end
            default: begin
                state_d = ECHO_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk12_i) begin
        if (rst_i) begin
            state_q    <= ECHO_IDLE;
            rd_en_q    <= 1'b0;
            wr_en_q    <= 1'b0;
            inflight_q <= 2'd0;
        end else begin
            state_q    <= state_d;
            rd_en_q    <= issue;
            // read data is registered in the OUT buffer and written one cycle later.
            wr_en_q    <= rd_en_q;
            inflight_q <= inflight_q + {1'b0, issue} - {1'b0, wr_en_q};
        end
    end

    assign out_rd_en_o  = rd_en_q;
    assign in_wr_en_o   = wr_en_q;
    assign in_wr_data_o = out_rd_data_i;

    // one byte in the read stage and one in the write stage at most.
    // every byte in flight still has its place in the IN buffer.
    a_inflight_bound: assert property (
        @(posedge clk12_i) disable iff (rst_i)
        (inflight_q <= 2'd2) && (in_free_i >= ep_level_t'(inflight_q))
    ) else $error("ep_echo_engine: bytes in flight exceed the bound or the IN space");

endmodule

`default_nettype wire

// File: logic/ep_echo_top.sv
`default_nettype none

`include "ep_echo_config.svh"

// single bulk endpoint pair that echoes every committed OUT packet.
// port names are device centric, as seen by the usb device controller.
module ep_echo_top (
    input  wire logic                  clk12_i,
    input  wire logic                  rst_i,

    input  wire logic                  ep_out_data_valid_i,
    input  wire ep_echo_pkg::ep_byte_t ep_out_data_i,
    input  wire logic                  ep_out_fill_trans_done_i,
    input  wire logic                  ep_out_fill_trans_success_i,
    output logic                       ep_out_full_o,

    input  wire logic                  ep_in_pop_data_i,
    input  wire logic                  ep_in_pop_trans_done_i,
    input  wire logic                  ep_in_pop_trans_success_i,
    output logic                       ep_in_data_available_o,
    output ep_echo_pkg::ep_byte_t      ep_in_data_o
);

    import ep_echo_pkg::*;

    // OUT buffer to engine.
    logic      out_rd_en;
    ep_byte_t  out_rd_data;
    ep_level_t out_level;

    // engine to IN buffer.
    logic      in_wr_en;
    ep_byte_t  in_wr_data;
    ep_level_t in_free;

    ep_out_buffer out_buf (
        .clk12_i              (clk12_i),
        .rst_i                (rst_i),
        .data_valid_i         (ep_out_data_valid_i),
        .data_i               (ep_out_data_i),
        .fill_trans_done_i    (ep_out_fill_trans_done_i),
        .fill_trans_success_i (ep_out_fill_trans_success_i),
        .full_o               (ep_out_full_o),
        .rd_en_i              (out_rd_en),
        .rd_data_o            (out_rd_data),
        .level_o              (out_level)
    );

    ep_echo_engine echo (
        .clk12_i       (clk12_i),
        .rst_i         (rst_i),
        .out_level_i   (out_level),
        .out_rd_en_o   (out_rd_en),
        .out_rd_data_i (out_rd_data),
        .in_free_i     (in_free),
        .in_wr_en_o    (in_wr_en),
        .in_wr_data_o  (in_wr_data)
    );

    ep_in_buffer in_buf (
        .clk12_i             (clk12_i),
        .rst_i               (rst_i),
        .wr_en_i             (in_wr_en),
        .wr_data_i           (in_wr_data),
        .free_o              (in_free),
        .pop_data_i          (ep_in_pop_data_i),
        .pop_trans_done_i    (ep_in_pop_trans_done_i),
        .pop_trans_success_i (ep_in_pop_trans_success_i),
        .data_available_o    (ep_in_data_available_o),
        .data_o              (ep_in_data_o)
    );

endmodule

`default_nettype wire

// File: verification/ep_echo_tb_cases.svh
`ifndef EP_ECHO_TB_CASES_SVH
`define EP_ECHO_TB_CASES_SVH

    // columns: name, bytes per OUT packet, OUT packets sent back to back,
    // OUT success, failed IN attempts before the good one, bytes echoed.
    localparam int NUM_CASES = 9;

    string case_name      [NUM_CASES];
    int    case_len       [NUM_CASES];
    int    case_packets   [NUM_CASES];
    logic  case_ok        [NUM_CASES];
    int    case_in_fails  [NUM_CASES];
    int    case_exp_bytes [NUM_CASES];

    task automatic set_case(input int idx, input string name, input int len,
                            input int packets, input logic ok, input int in_fails,
                            input int exp_bytes);
        case_name[idx]      = name;
        case_len[idx]       = len;
        case_packets[idx]   = packets;
        case_ok[idx]        = ok;
        case_in_fails[idx]  = in_fails;
        case_exp_bytes[idx] = exp_bytes;
    endtask

    task automatic load_cases();
        set_case(0, "single_byte",        1,  1, 1'b1, 0, 1);
        set_case(1, "short_packet",       8,  1, 1'b1, 0, 8);
        set_case(2, "max_packet",         64, 1, 1'b1, 0, 64);
        set_case(3, "out_fail_dropped",   20, 1, 1'b0, 0, 0);
        set_case(4, "after_drop",         12, 1, 1'b1, 0, 12);
        set_case(5, "in_retry_once",      16, 1, 1'b1, 1, 16);
        set_case(6, "in_retry_twice",     33, 1, 1'b1, 2, 33);
        // more than both buffers hold, so OUT must push back.
        set_case(7, "stall_backpressure", 60, 3, 1'b1, 0, 180);
        set_case(8, "stall_with_retry",   50, 3, 1'b1, 1, 150);
    endtask

    // xorshift32 step, the low byte of the state is the payload byte.
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

`endif

// File: verification/ep_echo_tb.sv
`default_nettype none

`include "ep_echo_config.svh"

// echo endpoint testbench.
// OUT packets go in at the controller side and come back at the IN side.
module ep_echo_tb;

    import ep_echo_pkg::*;

    `include "ep_echo_tb_cases.svh"

    // cycles from the OUT commit pulse to the first byte shown at IN.
    localparam int FIRST_BYTE_LAT = 4;

    logic        clk12;
    logic        rst;
    logic        out_valid;
    ep_byte_t    out_data;
    logic        out_done;
    logic        out_success;
    logic        out_full;
    logic        in_pop;
    logic        in_done;
    logic        in_success;
    logic        in_avail;
    ep_byte_t    in_data;

    // committed OUT bytes still owed by the IN side.
    ep_byte_t    ref_q[$];
    logic [31:0] rng_state;
    int          err_count;
    int          pass_cases;
    int          fail_cases;
    int          cycle_count;
    int          cycle_limit;

    ep_echo_top uut (
        .clk12_i                     (clk12),
        .rst_i                       (rst),
        .ep_out_data_valid_i         (out_valid),
        .ep_out_data_i               (out_data),
        .ep_out_fill_trans_done_i    (out_done),
        .ep_out_fill_trans_success_i (out_success),
        .ep_out_full_o               (out_full),
        .ep_in_pop_data_i            (in_pop),
        .ep_in_pop_trans_done_i      (in_done),
        .ep_in_pop_trans_success_i   (in_success),
        .ep_in_data_available_o      (in_avail),
        .ep_in_data_o                (in_data)
    );

    always #2 clk12 = ~clk12;

    always @(posedge clk12) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic check_byte(input string name, input ep_byte_t exp, input ep_byte_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected 0x%02h, actual 0x%02h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
            err_count++;
        end
    endtask

    // full is looked at one idle cycle after each write, once it has settled.
    task automatic send_byte(input ep_byte_t b);
        @(posedge clk12);
        while (out_full) begin
            @(posedge clk12);
        end
        out_valid <= 1'b1;
        out_data  <= b;
        @(posedge clk12);
        out_valid <= 1'b0;
    endtask

    task automatic write_packet(input int len, input logic ok);
        ep_byte_t pend[$];
        ep_byte_t b;
        for (int i = 0; i < len; i++) begin
            rng_state = xorshift32(rng_state);
            b = rng_state[7:0];
            pend.push_back(b);
            send_byte(b);
        end
        @(posedge clk12);
        out_done    <= 1'b1;
        out_success <= ok;
        if (ok) begin
            foreach (pend[i]) begin
                ref_q.push_back(pend[i]);
            end
        end
        @(posedge clk12);
        out_done    <= 1'b0;
        out_success <= 1'b0;
    endtask

    // pops n bytes of one IN transaction and compares them with the queue head.
    task automatic pop_packet(input string name, input int n);
        int i;
        i = 0;
        while (i < n) begin
            @(posedge clk12);
            if (in_avail) begin
                if (i < ref_q.size()) begin
                    check_byte(name, ref_q[i], in_data);
                end else begin
                    $display("%s: the IN port shows a byte that was never committed", name);
                    err_count++;
                end
                in_pop <= 1'b1;
                @(posedge clk12);
                in_pop <= 1'b0;
                i++;
            end
        end
    endtask

    task automatic end_in_trans(input logic ok);
        @(posedge clk12);
        in_done    <= 1'b1;
        in_success <= ok;
        @(posedge clk12);
        in_done    <= 1'b0;
        in_success <= 1'b0;
    endtask

    task automatic drain_in(input string name, input int total, input int fails);
        int       left;
        int       n;
        ep_byte_t drop;
        left = total;
        while (left > 0) begin
            n = (left > `EP_BUF_DEPTH) ? `EP_BUF_DEPTH : left;
            // every failed attempt rewinds, so each retry sees the same bytes.
            for (int a = 0; a <= fails; a++) begin
                pop_packet(name, n);
                end_in_trans(a == fails);
            end
            for (int k = 0; k < n; k++) begin
                drop = ref_q.pop_front();
            end
            left -= n;
        end
    endtask

    task automatic watch_idle(input string name, input int cycles);
        repeat (cycles) begin
            @(posedge clk12);
            check_flag({name, " in available"}, 1'b0, in_avail);
        end
    endtask

    task automatic note_result(input string name, input int errs_before);
        if (err_count == errs_before) begin
            pass_cases++;
            $display("[PASS] %s", name);
        end else begin
            fail_cases++;
            $display("[FAIL] %s with %0d errors", name, err_count - errs_before);
        end
    endtask

    task automatic run_case(input int idx);
        string name;
        int    errs_before;
        name = case_name[idx];
        errs_before = err_count;
        if (case_packets[idx] > 1) begin
            fork
                begin
                    for (int p = 0; p < case_packets[idx]; p++) begin
                        write_packet(case_len[idx], case_ok[idx]);
                    end
                end
                begin
                    // no pops until OUT reports full.
                    @(posedge clk12);
                    while (!out_full) begin
                        @(posedge clk12);
                    end
                    drain_in(name, case_exp_bytes[idx], case_in_fails[idx]);
                end
            join
        end else begin
            write_packet(case_len[idx], case_ok[idx]);
            if (case_exp_bytes[idx] > 0) begin
                for (int n = 1; n <= FIRST_BYTE_LAT; n++) begin
                    @(posedge clk12);
                    check_flag({name, " first byte timing"}, n == FIRST_BYTE_LAT, in_avail);
                end
                drain_in(name, case_exp_bytes[idx], case_in_fails[idx]);
            end
        end
        watch_idle(name, 12);
        check_flag({name, " out full"}, 1'b0, out_full);
        if (ref_q.size() != 0) begin
            $display("%s: %0d committed bytes never came back", name, ref_q.size());
            err_count++;
        end
        note_result(name, errs_before);
    endtask

    initial begin
        int errs_before;
        clk12       = 1'b0;
        rst         <= 1'b1;
        out_valid   <= 1'b0;
        out_data    <= '0;
        out_done    <= 1'b0;
        out_success <= 1'b0;
        in_pop      <= 1'b0;
        in_done     <= 1'b0;
        in_success  <= 1'b0;
        rng_state   = 32'd15;
        load_cases();
        cycle_limit = 0;
        for (int i = 0; i < NUM_CASES; i++) begin
            cycle_limit += 20 * case_len[i] * case_packets[i] + 200;
        end
        repeat (5) @(posedge clk12);
        rst <= 1'b0;
        @(posedge clk12);
        errs_before = err_count;
        check_flag("reset out full", 1'b0, out_full);
        check_flag("reset in available", 1'b0, in_avail);
        note_result("reset_state", errs_before);
        for (int i = 0; i < NUM_CASES; i++) begin
            run_case(i);
        end
        $display("summary: %0d passed, %0d failed", pass_cases, fail_cases);
        if (fail_cases == 0 && err_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: ep_echo.f
+incdir+logic
+incdir+verification
logic/ep_echo_pkg.sv
logic/ep_out_buffer.sv
logic/ep_in_buffer.sv
logic/ep_echo_engine.sv
logic/ep_echo_top.sv
verification/ep_echo_tb.sv

// File: Bender.yml
package:
  name: ep_echo

sources:
  - include_dirs:
      - logic
    files:
      - logic/ep_echo_pkg.sv
      - logic/ep_out_buffer.sv
      - logic/ep_in_buffer.sv
      - logic/ep_echo_engine.sv
      - logic/ep_echo_top.sv

  - target: test
    include_dirs:
      - logic
      - verification
    files:
      - verification/ep_echo_tb.sv
